// ==== chdr_port_pkg.sv ====
// CHDR port lane definitions
`default_nettype none

package chdr_port_pkg;

  // --------------------------------------------------------------------------
  // Stream word
  // --------------------------------------------------------------------------

  localparam int chdr_w     = 64;
  localparam int beat_bytes = chdr_w / 8;

  // Header field widths
  localparam int len_w  = 16;
  localparam int epid_w = 16;

  // --------------------------------------------------------------------------
  // Transport prefix and port_info fields
  // --------------------------------------------------------------------------

  // Version 1.0, major in the upper byte
  localparam logic [15:0] rfnoc_protover = {8'd1, 8'd0};
  localparam int          portnum_w      = 8;
  localparam int          inst_w         = 8;

  localparam int pkt_cnt_w = 16;
  localparam int err_cnt_w = 8;
  localparam int info_w    = portnum_w + err_cnt_w + pkt_cnt_w;

  // CHDR header, first beat of every packet
  typedef struct packed {
    logic [5:0]        vc;
    logic              eob;
    logic              eov;
    logic [2:0]        pkt_type;
    logic [4:0]        num_mdata;
    logic [15:0]       seq_num;
    logic [len_w-1:0]  length;
    logic [epid_w-1:0] dst_epid;
  } chdr_hdr_t;

  // Same beat seen as payload or as header
  typedef union packed {
    logic [chdr_w-1:0] raw;
    chdr_hdr_t         hdr;
  } chdr_word_u;

endpackage

`default_nettype wire

// ==== chdr_hdr_parse.sv ====
// CHDR header parse stage
`timescale 1ns/1ps
`default_nettype none

module chdr_hdr_parse (
  input  wire logic                      bus_clk,
  input  wire logic                      reset,

  input  wire chdr_port_pkg::chdr_word_u s_tdata,
  input  wire logic                      s_tlast,
  input  wire logic                      s_tvalid,
  output logic                           s_tready,

  output chdr_port_pkg::chdr_word_u      m_tdata,
  output logic                           m_tlast,
  output logic                           m_tvalid,
  output logic                           m_hdr,
  output logic                           m_len_err,
  input  wire logic                      m_tready
);

  import chdr_port_pkg::*;

  logic             sop;
  logic [len_w-1:0] len_q;
  logic [len_w-1:0] cnt_q;
  logic [len_w-1:0] cur_len;
  logic [len_w-1:0] cur_cnt;
  logic             len_bad;
  logic             s_xfer;

  assign s_tready = !m_tvalid || m_tready;
  assign s_xfer   = s_tvalid && s_tready;

  // Header beat takes length and count from the word itself
  always_comb begin
    cur_len = sop ? s_tdata.hdr.length : len_q;
    cur_cnt = sop ? len_w'(1) : cnt_q + len_w'(1);
    len_bad = 32'(cur_len) != 32'(beat_bytes) * 32'(cur_cnt);
  end

  // --------------------------------------------------------------------------
  // Packet tracking
  // --------------------------------------------------------------------------

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      sop <= 1'b1;
    end else if (s_xfer) begin
      sop <= s_tlast;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (s_xfer) begin
      len_q <= cur_len;
      cnt_q <= cur_cnt;
    end
  end

  // --------------------------------------------------------------------------
  // Output register
  // --------------------------------------------------------------------------

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      m_tvalid <= 1'b0;
    end else if (s_tready) begin
      m_tvalid <= s_tvalid;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (s_xfer) begin
      m_tdata   <= s_tdata;
      m_tlast   <= s_tlast;
      m_hdr     <= sop;
      m_len_err <= s_tlast && len_bad;
    end
  end

  a_valid_known : assert property (
    @(posedge bus_clk) disable iff (reset) !$isunknown(m_tvalid)
  );

endmodule

`default_nettype wire

// ==== chdr_net_encap.sv ====
// Transport prefix insertion stage
`timescale 1ns/1ps
`default_nettype none

module chdr_net_encap #(
  parameter logic [chdr_port_pkg::portnum_w-1:0] portnum   = '0,
  parameter logic [chdr_port_pkg::inst_w-1:0]    node_inst = '0
) (
  input  wire logic                      bus_clk,
  input  wire logic                      reset,

  input  wire chdr_port_pkg::chdr_word_u s_tdata,
  input  wire logic                      s_tlast,
  input  wire logic                      s_tvalid,
  input  wire logic                      s_hdr,
  input  wire logic                      s_len_err,
  output logic                           s_tready,

  output chdr_port_pkg::chdr_word_u      m_tdata,
  output logic                           m_tlast,
  output logic                           m_tvalid,
  output logic                           m_len_err,
  input  wire logic                      m_tready
);

  import chdr_port_pkg::*;

  // High while the prefix is out and the header waits behind it
  logic       pend;
  chdr_word_u hold_tdata;
  logic       hold_tlast;
  logic       hold_len_err;
  chdr_word_u prefix;
  logic       s_xfer;

  assign s_tready = !pend && (!m_tvalid || m_tready);
  assign s_xfer   = s_tvalid && s_tready;

  // Version, port, instance, length, destination EPID
  assign prefix.raw = {rfnoc_protover, portnum, node_inst,
                       s_tdata.hdr.length, s_tdata.hdr.dst_epid};

  // --------------------------------------------------------------------------
  // Control
  // --------------------------------------------------------------------------

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      m_tvalid <= 1'b0;
      pend     <= 1'b0;
    end else if (s_xfer) begin
      m_tvalid <= 1'b1;
      pend     <= s_hdr;
    end else if (m_tready) begin
      // Prefix leaving keeps valid up for the held header
      m_tvalid <= pend;
      pend     <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Data path
  // --------------------------------------------------------------------------

  always_ff @(posedge bus_clk) begin
    if (s_xfer) begin
      if (s_hdr) begin
        m_tdata      <= prefix;
        m_tlast      <= 1'b0;
        m_len_err    <= 1'b0;
        hold_tdata   <= s_tdata;
        hold_tlast   <= s_tlast;
        hold_len_err <= s_len_err;
      end else begin
        m_tdata   <= s_tdata;
        m_tlast   <= s_tlast;
        m_len_err <= s_len_err;
      end
    end else if (pend && m_tready) begin
      m_tdata   <= hold_tdata;
      m_tlast   <= hold_tlast;
      m_len_err <= hold_len_err;
    end
  end

  a_hold_stall : assert property (
    @(posedge bus_clk) disable iff (reset)
    m_tvalid && !m_tready |=> $stable(m_tdata.raw)
  );

endmodule

`default_nettype wire

// ==== chdr_port_stats.sv ====
// Output slice and port statistics
`timescale 1ns/1ps
`default_nettype none

module chdr_port_stats #(
  parameter logic [chdr_port_pkg::portnum_w-1:0] portnum = '0
) (
  input  wire logic                          bus_clk,
  input  wire logic                          reset,

  input  wire chdr_port_pkg::chdr_word_u     s_tdata,
  input  wire logic                          s_tlast,
  input  wire logic                          s_tvalid,
  input  wire logic                          s_len_err,
  output logic                               s_tready,

  output chdr_port_pkg::chdr_word_u          m_tdata,
  output logic                               m_tlast,
  output logic                               m_tvalid,
  input  wire logic                          m_tready,

  output logic [chdr_port_pkg::info_w-1:0]   port_info
);

  import chdr_port_pkg::*;

  logic                 len_err_q;
  logic [pkt_cnt_w-1:0] pkt_cnt;
  logic [err_cnt_w-1:0] err_cnt;
  logic                 m_eop;

  assign s_tready = !m_tvalid || m_tready;
  assign m_eop    = m_tvalid && m_tready && m_tlast;

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      m_tvalid <= 1'b0;
    end else if (s_tready) begin
      m_tvalid <= s_tvalid;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (s_tvalid && s_tready) begin
      m_tdata   <= s_tdata;
      m_tlast   <= s_tlast;
      len_err_q <= s_len_err;
    end
  end

  // --------------------------------------------------------------------------
  // Counters, both wrap
  // --------------------------------------------------------------------------

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      pkt_cnt <= '0;
      err_cnt <= '0;
    end else if (m_eop) begin
      pkt_cnt <= pkt_cnt + 1'b1;
      if (len_err_q) begin
        err_cnt <= err_cnt + 1'b1;
      end
    end
  end

  assign port_info = {portnum, err_cnt, pkt_cnt};

  a_pkt_cnt_step : assert property (
    @(posedge bus_clk) disable iff (reset)
    !$stable(pkt_cnt) |-> $past(m_eop)
  );

endmodule

`default_nettype wire

// ==== chdr_port_top.sv ====
// CHDR transport port lane
`timescale 1ns/1ps
`default_nettype none

module chdr_port_top #(
  parameter logic [chdr_port_pkg::portnum_w-1:0] portnum   = '0,
  parameter logic [chdr_port_pkg::inst_w-1:0]    node_inst = '0
) (
  input  wire logic                        bus_clk,
  input  wire logic                        reset,

  // From the crossbar
  input  wire chdr_port_pkg::chdr_word_u   v2e_tdata,
  input  wire logic                        v2e_tlast,
  input  wire logic                        v2e_tvalid,
  output logic                             v2e_tready,

  // Toward the network
  output chdr_port_pkg::chdr_word_u        net_tdata,
  output logic                             net_tlast,
  output logic                             net_tvalid,
  input  wire logic                        net_tready,

  output logic [chdr_port_pkg::info_w-1:0] port_info
);

  import chdr_port_pkg::*;

  chdr_word_u hp_tdata;
  logic       hp_tlast;
  logic       hp_tvalid;
  logic       hp_tready;
  logic       hp_hdr;
  logic       hp_len_err;

  chdr_word_u en_tdata;
  logic       en_tlast;
  logic       en_tvalid;
  logic       en_tready;
  logic       en_len_err;

  chdr_hdr_parse u_chdr_hdr_parse (
    .bus_clk   (bus_clk),
    .reset     (reset),
    .s_tdata   (v2e_tdata),
    .s_tlast   (v2e_tlast),
    .s_tvalid  (v2e_tvalid),
    .s_tready  (v2e_tready),
    .m_tdata   (hp_tdata),
    .m_tlast   (hp_tlast),
    .m_tvalid  (hp_tvalid),
    .m_hdr     (hp_hdr),
    .m_len_err (hp_len_err),
    .m_tready  (hp_tready)
  );

  chdr_net_encap #(
    .portnum   (portnum),
    .node_inst (node_inst)
  ) u_chdr_net_encap (
    .bus_clk   (bus_clk),
    .reset     (reset),
    .s_tdata   (hp_tdata),
    .s_tlast   (hp_tlast),
    .s_tvalid  (hp_tvalid),
    .s_hdr     (hp_hdr),
    .s_len_err (hp_len_err),
    .s_tready  (hp_tready),
    .m_tdata   (en_tdata),
    .m_tlast   (en_tlast),
    .m_tvalid  (en_tvalid),
    .m_len_err (en_len_err),
    .m_tready  (en_tready)
  );

  chdr_port_stats #(
    .portnum   (portnum)
  ) u_chdr_port_stats (
    .bus_clk   (bus_clk),
    .reset     (reset),
    .s_tdata   (en_tdata),
    .s_tlast   (en_tlast),
    .s_tvalid  (en_tvalid),
    .s_len_err (en_len_err),
    .s_tready  (en_tready),
    .m_tdata   (net_tdata),
    .m_tlast   (net_tlast),
    .m_tvalid  (net_tvalid),
    .m_tready  (net_tready),
    .port_info (port_info)
  );

endmodule

`default_nettype wire

// ==== tb_chdr_port.sv ====
// CHDR port lane testbench
`timescale 1ns/1ps
`default_nettype none

module tb_chdr_port;

  import chdr_port_pkg::*;

  localparam int          num_pkts     = 200;
  localparam int          max_beats    = 8;
  localparam int          cycle_limit  = num_pkts * (max_beats + 1) * 4 + 1000;
  localparam logic [7:0]  tb_portnum   = 8'd3;
  localparam logic [7:0]  tb_node_inst = 8'd1;
  localparam logic [31:0] seed         = 32'h7ccbc3ff;

  logic              bus_clk;
  logic              reset;
  chdr_word_u        v2e_tdata;
  logic              v2e_tlast;
  logic              v2e_tvalid;
  logic              v2e_tready;
  chdr_word_u        net_tdata;
  logic              net_tlast;
  logic              net_tvalid;
  logic              net_tready;
  logic [info_w-1:0] port_info;

  logic [31:0] rng_state;
  chdr_word_u  in_word[$];
  logic        in_last[$];
  chdr_word_u  exp_word[$];
  logic        exp_last[$];
  logic        exp_err[$];
  int          in_idx;
  int          bad_total;
  int          pkts_out;
  int          errs_out;
  int          err_count;
  int          check_count;
  int          cycle_cnt;
  logic        running;
  logic        info_due;
  logic        stalled;
  chdr_word_u  stall_word;
  logic        stall_last;
  string       test_name;

  chdr_port_top #(
    .portnum   (tb_portnum),
    .node_inst (tb_node_inst)
  ) u_chdr_port_top (
    .bus_clk    (bus_clk),
    .reset      (reset),
    .v2e_tdata  (v2e_tdata),
    .v2e_tlast  (v2e_tlast),
    .v2e_tvalid (v2e_tvalid),
    .v2e_tready (v2e_tready),
    .net_tdata  (net_tdata),
    .net_tlast  (net_tlast),
    .net_tvalid (net_tvalid),
    .net_tready (net_tready),
    .port_info  (port_info)
  );

  initial bus_clk = 1'b0;
  always #20 bus_clk = ~bus_clk;

  // ---------------------------------------------------------------------------
  // Random numbers and compare tasks
  // ---------------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check_word(input string what, input chdr_word_u exp, input chdr_word_u act);
    check_count++;
    if (act.raw !== exp.raw) begin
      $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp.raw, act.raw);
      err_count++;
    end
  endtask

  task automatic check_last(input string what, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_info(input string what, input logic [info_w-1:0] exp,
                            input logic [info_w-1:0] act);
    check_count++;
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic report_test(input int errs_at_start);
    $display("%s finished with %0d errors", test_name, err_count - errs_at_start);
  endtask

  // Input beats and the expected network words, prefix first
  task automatic build_packets();
    chdr_word_u  hdr;
    chdr_word_u  word;
    chdr_word_u  prefix;
    int          nbeats;
    logic [15:0] good_len;
    for (int p = 0; p < num_pkts; p++) begin
      nbeats   = 1 + int'(rand32() % max_beats);
      hdr.raw  = {rand32(), rand32()};
      good_len = 16'(beat_bytes * nbeats);
      hdr.hdr.length = good_len;
      if (rand32() % 8 == 0) begin
        hdr.hdr.length = 16'(rand32());
      end
      exp_err.push_back(hdr.hdr.length != good_len);
      if (hdr.hdr.length != good_len) begin
        bad_total++;
      end
      prefix.raw = {rfnoc_protover, tb_portnum, tb_node_inst,
                    hdr.hdr.length, hdr.hdr.dst_epid};
      exp_word.push_back(prefix);
      exp_last.push_back(1'b0);
      for (int b = 0; b < nbeats; b++) begin
        word.raw = (b == 0) ? hdr.raw : {rand32(), rand32()};
        in_word.push_back(word);
        in_last.push_back(b == nbeats - 1);
        exp_word.push_back(word);
        exp_last.push_back(b == nbeats - 1);
      end
    end
  endtask

  // ---------------------------------------------------------------------------
  // Stimulus and output checking
  // ---------------------------------------------------------------------------

  always @(posedge bus_clk) begin : traffic
    chdr_word_u exp_w;
    logic       exp_l;
    logic       take;
    if (running) begin
      take = v2e_tvalid && v2e_tready;
      if (take) begin
        in_idx = in_idx + 1;
      end
      // A stalled input beat stays put
      if (!v2e_tvalid || take) begin
        if (in_idx < in_word.size() && rand32() % 4 != 0) begin
          v2e_tvalid <= 1'b1;
          v2e_tdata  <= in_word[in_idx];
          v2e_tlast  <= in_last[in_idx];
        end else begin
          v2e_tvalid <= 1'b0;
        end
      end

      if (info_due) begin
        check_info("port_info after packet",
                   {tb_portnum, 8'(errs_out), 16'(pkts_out)}, port_info);
      end
      info_due = 1'b0;

      if (stalled) begin
        if (net_tvalid !== 1'b1) begin
          $display("Error in %s: net_tvalid dropped while a beat was stalled", test_name);
          err_count++;
        end
        check_word("stalled data", stall_word, net_tdata);
        check_last("stalled last", stall_last, net_tlast);
      end

      if (net_tvalid && net_tready) begin
        if (exp_word.size() == 0) begin
          $display("Error in %s: an output beat arrived with none expected", test_name);
          err_count++;
        end else begin
          exp_w = exp_word.pop_front();
          exp_l = exp_last.pop_front();
          check_word("beat data", exp_w, net_tdata);
          check_last("beat last", exp_l, net_tlast);
          if (exp_l) begin
            pkts_out++;
            if (exp_err.pop_front()) begin
              errs_out++;
            end
            info_due = 1'b1;
          end
        end
      end

      stalled    = net_tvalid && !net_tready;
      stall_word = net_tdata;
      stall_last = net_tlast;
      net_tready <= (rand32() % 4 != 0);
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge bus_clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Test failed");
    $finish;
  end

  initial begin : main
    int errs_at_start;
    rng_state   = seed;
    reset       = 1'b1;
    v2e_tdata   = '0;
    v2e_tlast   = 1'b0;
    v2e_tvalid  = 1'b0;
    net_tready  = 1'b0;
    running     = 1'b0;
    info_due    = 1'b0;
    stalled     = 1'b0;
    stall_word  = '0;
    stall_last  = 1'b0;
    in_idx      = 0;
    bad_total   = 0;
    pkts_out    = 0;
    errs_out    = 0;
    err_count   = 0;
    check_count = 0;
    build_packets();
    repeat (8) @(posedge bus_clk);
    reset <= 1'b0;

    test_name     = "reset_idle";
    errs_at_start = err_count;
    @(posedge bus_clk);
    if (net_tvalid !== 1'b0) begin
      $display("Error in %s: net_tvalid is not low after reset", test_name);
      err_count++;
    end
    check_info("port_info", {tb_portnum, 24'd0}, port_info);
    report_test(errs_at_start);

    test_name     = "random_traffic";
    errs_at_start = err_count;
    running <= 1'b1;
    while (pkts_out < num_pkts || info_due) begin
      @(negedge bus_clk);
    end
    report_test(errs_at_start);

    test_name     = "final_counts";
    errs_at_start = err_count;
    check_info("port_info totals", {tb_portnum, 8'(bad_total), 16'(num_pkts)}, port_info);
    // Drained lane shows no further beat and accepts input again
    if (net_tvalid !== 1'b0) begin
      $display("Error in %s: an extra output beat follows the last packet", test_name);
      err_count++;
    end
    if (v2e_tready !== 1'b1) begin
      $display("Error in %s: v2e_tready is not high once the lane is empty", test_name);
      err_count++;
    end
    report_test(errs_at_start);

    $display("Checks run %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
chdr_port_pkg.sv
chdr_hdr_parse.sv
chdr_net_encap.sv
chdr_port_stats.sv
chdr_port_top.sv
tb_chdr_port.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the CHDR port lane simulation with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_chdr_port \
  -Mdir "$build_dir" -o tb_chdr_port -f sim.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$build_dir/tb_chdr_port" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test completed successfully" "$log_file"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
